//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter-out +incdir+%,$(shell cat vlog.f))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): vlog.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f vlog.f -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// byte address width of the data RAM.
`define LSU_ADDR_W 12

`define LSU_RAM_WORDS (1 << (`LSU_ADDR_W - 2))

// load/store operation codes.
`define LSU_OP_LB  3'd0
`define LSU_OP_LH  3'd1
`define LSU_OP_LW  3'd2
`define LSU_OP_LBU 3'd3
`define LSU_OP_LHU 3'd4
`define LSU_OP_SB  3'd5
`define LSU_OP_SH  3'd6
`define LSU_OP_SW  3'd7

`endif

//--- rtl/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [31:0]             word_t;
    typedef logic [`LSU_ADDR_W-1:0]  addr_t;
    typedef logic [3:0]              byte_en_t;
    typedef logic [2:0]              ls_op_t;

    typedef struct packed {
        ls_op_t op;
        addr_t  addr;
        word_t  wdata;
    } lsu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  load_addr_error;
        logic  store_addr_error;
    } lsu_resp_t;

    // word addressed, as the RAM sees it.
    typedef struct packed {
        logic [`LSU_ADDR_W-3:0] adr;
        word_t                  dat;
        byte_en_t               sel;
        logic                   we;
    } wb_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } wb_state_e;

endpackage

//--- rtl/lsu_req_stage.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_req_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    output logic              req_ready,
    input  logic              done,
    output lsu_pkg::lsu_req_t held,
    output logic              held_valid,
    output logic              misaligned
);

    logic accept;

    assign req_ready = !held_valid; // one slot only.
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (accept) begin
            held_valid <= 1'b1;
        end else if (done) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= req;
        end
    end

    // word needs 00, halfword needs an even address.
    always_comb begin
        case (held.op)
            `LSU_OP_LW,
            `LSU_OP_SW: begin
                misaligned = (held.addr[1:0] != 2'b00);
            end
            `LSU_OP_LH,
            `LSU_OP_LHU,
            `LSU_OP_SH: begin
                misaligned = held.addr[0];
            end
            default: begin
                misaligned = 1'b0; // bytes are always aligned.
            end
        endcase
    end

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp
);

    lsu_pkg::lsu_req_t held;
    logic              held_valid;
    logic              misaligned;
    logic              done;
    lsu_pkg::wb_req_t  bus_req;
    lsu_pkg::wb_req_t  wb_out;
    lsu_pkg::word_t    load_data;
    lsu_pkg::word_t    dat_r;
    logic              cyc;
    logic              stb;
    logic              ack;

    lsu_req_stage req_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .done       (done),
        .held       (held),
        .held_valid (held_valid),
        .misaligned (misaligned)
    );

    mem_ctrl mem_ctrl_i (
        .held      (held),
        .bus_rdata (dat_r),
        .bus_req   (bus_req),
        .load_data (load_data)
    );

    wb_data_master master_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .held_valid (held_valid),
        .misaligned (misaligned),
        .held_op    (held.op),
        .bus_req    (bus_req),
        .load_data  (load_data),
        .ack        (ack),
        .cyc        (cyc),
        .stb        (stb),
        .wb_out     (wb_out),
        .done       (done),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    wb_data_ram ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .bus   (wb_out),
        .ack   (ack),
        .dat_r (dat_r)
    );

endmodule

//--- rtl/mem_ctrl.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module mem_ctrl (
    input  lsu_pkg::lsu_req_t held,
    input  lsu_pkg::word_t    bus_rdata,
    output lsu_pkg::wb_req_t  bus_req,
    output lsu_pkg::word_t    load_data
);

    logic [1:0]        lane;
    logic [15:0]       rd_half;
    logic [7:0]        rd_byte;
    lsu_pkg::byte_en_t sel;
    lsu_pkg::word_t    wdata_rep;
    logic              is_store;

    assign lane = held.addr[1:0];

    always_comb begin
        sel       = 4'b1111; // loads fetch the whole word.
        wdata_rep = '0;
        is_store  = 1'b0;
        case (held.op)
            `LSU_OP_SW: begin
                wdata_rep = held.wdata;
                is_store  = 1'b1;
            end
            `LSU_OP_SH: begin
                sel       = lane[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{held.wdata[15:0]}};
                is_store  = 1'b1;
            end
            `LSU_OP_SB: begin
                sel       = 4'b0001 << lane;
                wdata_rep = {4{held.wdata[7:0]}};
                is_store  = 1'b1;
            end
            default: begin
                sel = 4'b1111;
            end
        endcase
    end

    always_comb begin
        bus_req.adr = held.addr[`LSU_ADDR_W-1:2];
        bus_req.dat = wdata_rep;
        bus_req.sel = sel;
        bus_req.we  = is_store;
    end

    // lane select on the returned word.
    assign rd_half = lane[1] ? bus_rdata[31:16] : bus_rdata[15:0];
    assign rd_byte = bus_rdata[8*lane +: 8];

    always_comb begin
        case (held.op)
            `LSU_OP_LW:  load_data = bus_rdata;
            `LSU_OP_LH:  load_data = {{16{rd_half[15]}}, rd_half};
            `LSU_OP_LHU: load_data = {16'b0, rd_half};
            `LSU_OP_LB:  load_data = {{24{rd_byte[7]}}, rd_byte};
            `LSU_OP_LBU: load_data = {24'b0, rd_byte};
            default:     load_data = '0; // stores return nothing.
        endcase
    end

endmodule

//--- rtl/wb_data_master.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module wb_data_master (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               held_valid,
    input  logic               misaligned,
    input  lsu_pkg::ls_op_t    held_op,
    input  lsu_pkg::wb_req_t   bus_req,
    input  lsu_pkg::word_t     load_data,
    input  logic               ack,
    output logic               cyc,
    output logic               stb,
    output lsu_pkg::wb_req_t   wb_out,
    output logic               done,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp
);

    lsu_pkg::wb_state_e state;
    lsu_pkg::wb_state_e state_nxt;
    logic               is_store;
    logic               start;
    logic               reject;

    assign is_store = (held_op == `LSU_OP_SB) || (held_op == `LSU_OP_SH) ||
                      (held_op == `LSU_OP_SW);

    assign start  = (state == lsu_pkg::ST_IDLE) && held_valid && !misaligned;
    assign reject = (state == lsu_pkg::ST_IDLE) && held_valid && misaligned;

    // cycle opens in the same cycle the request is held.
    assign cyc    = start || (state == lsu_pkg::ST_BUS);
    assign stb    = cyc;
    assign wb_out = cyc ? bus_req : '0; // held request keeps the fields stable.

    assign done       = (state == lsu_pkg::ST_DONE);
    assign resp_valid = done;

    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::ST_IDLE: begin
                if (start) begin
                    state_nxt = lsu_pkg::ST_BUS;
                end else if (reject) begin
                    state_nxt = lsu_pkg::ST_DONE;
                end
            end
            lsu_pkg::ST_BUS: begin
                if (ack) begin
                    state_nxt = lsu_pkg::ST_DONE;
                end
            end
            default: begin
                state_nxt = lsu_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lsu_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (reject) begin
            resp.rdata            <= '0;
            resp.load_addr_error  <= !is_store;
            resp.store_addr_error <= is_store;
        end else if ((state == lsu_pkg::ST_BUS) && ack) begin
            resp.rdata            <= is_store ? '0 : load_data;
            resp.load_addr_error  <= 1'b0;
            resp.store_addr_error <= 1'b0;
        end
    end

endmodule

//--- rtl/wb_data_ram.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module wb_data_ram (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cyc,
    input  logic             stb,
    input  lsu_pkg::wb_req_t bus,
    output logic             ack,
    output lsu_pkg::word_t   dat_r
);

    lsu_pkg::word_t mem [`LSU_RAM_WORDS];
    logic           access;

    // ack high blocks a second transfer.
    assign access = cyc && stb && !ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.sel[i]) begin
                        mem[bus.adr][8*i +: 8] <= bus.dat[8*i +: 8];
                    end
                end
            end
            dat_r <= mem[bus.adr]; // old word on a write.
        end
    end

endmodule

//--- tests/lsu_chk.sv
`timescale 1ns/1ns

module lsu_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             cyc,
    input logic             stb,
    input logic             ack,
    input lsu_pkg::wb_req_t bus
);

    int fail_count = 0; // read by the testbench at the end.

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n) stb |-> cyc)
        else begin
            fail_count++;
            $error("stb high while cyc is low");
        end

    // address, data, sel and we held until ack.
    fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (stb && !ack) |=> (stb && $stable(bus)))
        else begin
            fail_count++;
            $error("bus fields changed or stb dropped before ack");
        end

    single_ack: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else begin
            fail_count++;
            $error("ack high for two cycles");
        end

    store_sel: assert property (@(posedge clk) disable iff (!rst_n)
        (cyc && stb && bus.we) |-> (bus.sel != 4'b0000))
        else begin
            fail_count++;
            $error("store cycle with no byte selected");
        end

endmodule

bind wb_data_master lsu_chk master_chk_i (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .bus   (wb_out)
);

bind wb_data_ram lsu_chk ram_chk_i (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .bus   (bus)
);

//--- tests/lsu_tb.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_tb;

    localparam int N_OPS      = 300;
    localparam int CLK_NS     = 40;
    localparam int MAX_WAIT   = 8;
    localparam int TIMEOUT_NS = (N_OPS + `LSU_RAM_WORDS) * 8 * CLK_NS + 10 * CLK_NS;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    lsu_pkg::lsu_req_t  req;
    logic               req_ready;
    logic               resp_valid;
    lsu_pkg::lsu_resp_t resp;

    logic [31:0] seed;
    logic [7:0]  model_mem [`LSU_RAM_WORDS*4]; // byte model, little endian.
    int          value_errors;
    int          other_errors;

    lsu_top lsu_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with operations still running", TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_word(input string name, input lsu_pkg::word_t exp,
                              input lsu_pkg::word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected 0x%08h, got 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    function automatic lsu_pkg::word_t load_value(input lsu_pkg::ls_op_t op,
                                                   input lsu_pkg::addr_t a);
        lsu_pkg::word_t w;
        logic [15:0]    h;
        logic [7:0]     b;
        w = {model_mem[{a[`LSU_ADDR_W-1:2], 2'd3}], model_mem[{a[`LSU_ADDR_W-1:2], 2'd2}],
             model_mem[{a[`LSU_ADDR_W-1:2], 2'd1}], model_mem[{a[`LSU_ADDR_W-1:2], 2'd0}]};
        h = {model_mem[{a[`LSU_ADDR_W-1:1], 1'b1}], model_mem[{a[`LSU_ADDR_W-1:1], 1'b0}]};
        b = model_mem[a];
        case (op)
            `LSU_OP_LW:  return w;
            `LSU_OP_LH:  return {{16{h[15]}}, h};
            `LSU_OP_LHU: return {16'h0000, h};
            `LSU_OP_LB:  return {{24{b[7]}}, b};
            `LSU_OP_LBU: return {24'h000000, b};
            default:     return '0;
        endcase
    endfunction

    task automatic store_model(input lsu_pkg::ls_op_t op, input lsu_pkg::addr_t a,
                               input lsu_pkg::word_t d);
        case (op)
            `LSU_OP_SB: model_mem[a] = d[7:0];
            `LSU_OP_SH: begin
                model_mem[{a[`LSU_ADDR_W-1:1], 1'b0}] = d[7:0];
                model_mem[{a[`LSU_ADDR_W-1:1], 1'b1}] = d[15:8];
            end
            `LSU_OP_SW: begin
                for (int i = 0; i < 4; i++) begin
                    model_mem[{a[`LSU_ADDR_W-1:2], 2'(i)}] = d[8*i +: 8];
                end
            end
            default: ;
        endcase
    endtask

    // called just after a rising edge; returns just after the edge that follows the response.
    task automatic issue(input lsu_pkg::lsu_req_t r);
        logic           is_store;
        logic           mis;
        logic           got;
        lsu_pkg::word_t exp_rdata;
        int             exp_lat;
        int             lat;
        is_store = r.op inside {`LSU_OP_SB, `LSU_OP_SH, `LSU_OP_SW};
        case (r.op)
            `LSU_OP_LW, `LSU_OP_SW:               mis = (r.addr[1:0] != 2'b00);
            `LSU_OP_LH, `LSU_OP_LHU, `LSU_OP_SH: mis = r.addr[0];
            default:                              mis = 1'b0;
        endcase
        exp_rdata = (is_store || mis) ? '0 : load_value(r.op, r.addr);
        if (is_store && !mis) begin
            store_model(r.op, r.addr, r.wdata);
        end
        exp_lat = mis ? 2 : 3;
        req       <= r;
        req_valid <= 1'b1;
        @(negedge clk);
        check_flag("req_ready", 1'b1, req_ready);
        check_flag("resp_valid", 1'b0, resp_valid); // no stray second response.
        @(posedge clk); // accepted here.
        lat = 1;
        got = 1'b0;
        while (!got && lat <= MAX_WAIT) begin
            @(negedge clk);
            check_flag("req_ready", 1'b0, req_ready);
            if (resp_valid) begin
                got = 1'b1;
            end else begin
                @(posedge clk);
                lat++;
            end
        end
        if (!got) begin
            other_errors++;
            $display("no response to op %0d at address 0x%03h", r.op, r.addr);
        end else begin
            if (lat != exp_lat) begin
                other_errors++;
                $display("response came %0d edges after acceptance instead of %0d",
                         lat, exp_lat);
            end
            check_word("resp.rdata", exp_rdata, resp.rdata);
            check_flag("resp.load_addr_error", mis && !is_store, resp.load_addr_error);
            check_flag("resp.store_addr_error", mis && is_store, resp.store_addr_error);
        end
        @(posedge clk);
    endtask

    initial begin
        lsu_pkg::lsu_req_t r;
        logic [31:0]       rnd;
        seed         = 32'hac39d4e4;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < `LSU_RAM_WORDS*4; i++) begin
            model_mem[lsu_pkg::addr_t'(i)] = 8'h00;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("req_ready", 1'b1, req_ready);
        check_flag("resp_valid", 1'b0, resp_valid);
        @(posedge clk);
        for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
            r.op    = `LSU_OP_SW;
            r.addr  = lsu_pkg::addr_t'(w * 4);
            r.wdata = '0;
            issue(r);
        end
        for (int n = 0; n < N_OPS; n++) begin
            rnd    = next_rand();
            r.op   = rnd[31:29];
            r.addr = rnd[`LSU_ADDR_W+15:16];
            if (rnd[15:14] != 2'b00) begin
                r.addr[`LSU_ADDR_W-1:5] = '0; // small window so loads meet earlier stores.
            end
            r.wdata = next_rand();
            issue(r);
        end
        req_valid <= 1'b0;
        @(negedge clk);
        check_flag("resp_valid", 1'b0, resp_valid);
        other_errors += lsu_top_i.master_i.master_chk_i.fail_count +
                        lsu_top_i.ram_i.ram_chk_i.fail_count;
        $display("errors: %0d value, %0d protocol", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_req_stage.sv
rtl/mem_ctrl.sv
rtl/wb_data_master.sv
rtl/wb_data_ram.sv
rtl/lsu_top.sv
tests/lsu_chk.sv
tests/lsu_tb.sv
